// ==== hdl/axi_mux_pkg.sv ====
package axi_mux_pkg;

	// AXI4-Lite bus geometry
	localparam int axi_data_width = 32;
	localparam int axi_addr_width = 11;
	localparam int axi_strb_width = axi_data_width / 8;

	// Lowest address bit that selects a 32-bit register
	localparam int word_addr_lsb = $clog2(axi_strb_width);

	// Number of mapped registers, anything above answers with SLVERR
	localparam int n_reg = 2;

	// Datapath sizes
	localparam int n_inputs   = 4;
	localparam int lane_width = 8;
	localparam int sel_width  = 4;

	// AXI response codes
	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// Register layout, highest register first so that register 0 sits in the low word
	typedef struct packed {
		// Register 1
		logic [axi_data_width-1:0]           pad_reg1;
		// Register 0
		logic [axi_data_width-sel_width-1:0] pad_reg0;
		logic [sel_width-1:0]                sel;
	} mux_regs_t;

endpackage

// ==== hdl/axi_lite_ipif.sv ====
module axi_lite_ipif (
	input  logic                                   s_axi_aclk,
	input  logic                                   rst_n,
	input  logic [axi_mux_pkg::axi_addr_width-1:0] s_axi_awaddr,
	input  logic                                   s_axi_awvalid,
	output logic                                   s_axi_awready,
	input  logic [axi_mux_pkg::axi_data_width-1:0] s_axi_wdata,
	input  logic [axi_mux_pkg::axi_strb_width-1:0] s_axi_wstrb,
	input  logic                                   s_axi_wvalid,
	output logic                                   s_axi_wready,
	output logic [1:0]                             s_axi_bresp,
	output logic                                   s_axi_bvalid,
	input  logic                                   s_axi_bready,
	input  logic [axi_mux_pkg::axi_addr_width-1:0] s_axi_araddr,
	input  logic                                   s_axi_arvalid,
	output logic                                   s_axi_arready,
	output logic [axi_mux_pkg::axi_data_width-1:0] s_axi_rdata,
	output logic [1:0]                             s_axi_rresp,
	output logic                                   s_axi_rvalid,
	input  logic                                   s_axi_rready,
	output logic [axi_mux_pkg::axi_data_width-1:0] bus_data,
	output logic [axi_mux_pkg::axi_strb_width-1:0] bus_be,
	output logic [axi_mux_pkg::n_reg-1:0]          wr_ce,
	output logic [axi_mux_pkg::n_reg-1:0]          rd_ce,
	output logic                                   bus_rst_n,
	input  logic [axi_mux_pkg::axi_data_width-1:0] ip_data,
	input  logic                                   wr_ack,
	input  logic                                   rd_ack
);
	import axi_mux_pkg::*;

	localparam int word_addr_width = axi_addr_width - word_addr_lsb;

	typedef enum logic [2:0] {
		st_idle,
		st_wr_strobe,
		st_wr_wait,
		st_wr_resp,
		st_rd_strobe,
		st_rd_wait,
		st_rd_resp
	} state_t;

	state_t                     state;
	logic [axi_addr_width-1:0]  addr_q;
	logic [word_addr_width-1:0] word_addr;
	logic [n_reg-1:0]           ce_onehot;
	logic                       addr_err;
	logic                       wr_start;
	logic                       rd_start;
	logic                       wr_done;
	logic                       rd_done;

	// A write with both address and data present wins over a pending read
	assign wr_start = (state == st_idle) && s_axi_awvalid && s_axi_wvalid;
	assign rd_start = (state == st_idle) && s_axi_arvalid && !(s_axi_awvalid && s_axi_wvalid);

	// Decode the latched word address into one strobe bit per register
	assign word_addr = addr_q[axi_addr_width-1:word_addr_lsb];

	always_comb begin
		ce_onehot = '0;
		for (int i = 0; i < n_reg; i++) begin
			ce_onehot[i] = (word_addr == word_addr_width'(i));
		end
	end

	assign addr_err = ~|ce_onehot;

	// Strobes last exactly one cycle, an unmapped address never gets one
	assign wr_ce = (state == st_wr_strobe) ? ce_onehot : '0;
	assign rd_ce = (state == st_rd_strobe) ? ce_onehot : '0;

	// Unmapped accesses complete right after acceptance, mapped ones on the acknowledge
	assign wr_done = ((state == st_wr_strobe) && addr_err) || ((state == st_wr_wait) && wr_ack);
	assign rd_done = ((state == st_rd_strobe) && addr_err) || ((state == st_rd_wait) && rd_ack);

	assign s_axi_awready = wr_done;
	assign s_axi_wready  = wr_done;
	assign s_axi_arready = rd_done;

	// Register reset is released on a clock edge
	always_ff @(posedge s_axi_aclk or negedge rst_n) begin
		if (!rst_n) begin
			bus_rst_n <= 1'b0;
		end else begin
			bus_rst_n <= 1'b1;
		end
	end

	always_ff @(posedge s_axi_aclk) begin
		if (wr_start) begin
			addr_q   <= s_axi_awaddr;
			bus_data <= s_axi_wdata;
			bus_be   <= s_axi_wstrb;
		end else if (rd_start) begin
			addr_q <= s_axi_araddr;
		end
	end

	always_ff @(posedge s_axi_aclk) begin
		if (wr_done) begin
			s_axi_bresp <= addr_err ? resp_slverr : resp_okay;
		end
		if (rd_done) begin
			s_axi_rresp <= addr_err ? resp_slverr : resp_okay;
			s_axi_rdata <= addr_err ? '0 : ip_data;
		end
	end

	always_ff @(posedge s_axi_aclk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= st_idle;
			s_axi_bvalid <= 1'b0;
			s_axi_rvalid <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (wr_start) begin
						state <= st_wr_strobe;
					end else if (rd_start) begin
						state <= st_rd_strobe;
					end
				end
				st_wr_strobe, st_wr_wait: begin
					if (wr_done) begin
						s_axi_bvalid <= 1'b1;
						state        <= st_wr_resp;
					end else begin
						state <= st_wr_wait;
					end
				end
				st_wr_resp: begin
					if (s_axi_bready) begin
						s_axi_bvalid <= 1'b0;
						state        <= st_idle;
					end
				end
				st_rd_strobe, st_rd_wait: begin
					if (rd_done) begin
						s_axi_rvalid <= 1'b1;
						state        <= st_rd_resp;
					end else begin
						state <= st_rd_wait;
					end
				end
				st_rd_resp: begin
					if (s_axi_rready) begin
						s_axi_rvalid <= 1'b0;
						state        <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

// ==== hdl/ipif_param_regs.sv ====
module ipif_param_regs #(
	parameter type param_t = logic [axi_mux_pkg::axi_data_width-1:0],
	localparam int n_words = $bits(param_t) / axi_mux_pkg::axi_data_width
) (
	input  logic                                   s_axi_aclk,
	input  logic                                   bus_rst_n,
	input  logic [axi_mux_pkg::axi_data_width-1:0] bus_data,
	input  logic [axi_mux_pkg::axi_strb_width-1:0] bus_be,
	input  logic [n_words-1:0]                     wr_ce,
	input  logic [n_words-1:0]                     rd_ce,
	input  param_t                                 params_in,
	output logic [axi_mux_pkg::axi_data_width-1:0] ip_data,
	output logic                                   wr_ack,
	output logic                                   rd_ack,
	output param_t                                 params_out
);
	import axi_mux_pkg::*;

	// Word 0 of the array is the low word of the struct
	logic [n_words-1:0][axi_data_width-1:0] regs;
	logic [n_words-1:0][axi_data_width-1:0] readback;
	logic [axi_data_width-1:0]              rd_word;

	assign params_out = param_t'(regs);
	assign readback   = params_in;

	// Only bytes with their enable set are written
	always_ff @(posedge s_axi_aclk or negedge bus_rst_n) begin
		if (!bus_rst_n) begin
			regs <= '0;
		end else begin
			for (int w = 0; w < n_words; w++) begin
				for (int b = 0; b < axi_strb_width; b++) begin
					if (wr_ce[w] && bus_be[b]) begin
						regs[w][8*b +: 8] <= bus_data[8*b +: 8];
					end
				end
			end
		end
	end

	// At most one read strobe is high, so the words can be OR-ed together
	always_comb begin
		rd_word = '0;
		for (int w = 0; w < n_words; w++) begin
			if (rd_ce[w]) begin
				rd_word = rd_word | readback[w];
			end
		end
	end

	always_ff @(posedge s_axi_aclk) begin
		if (|rd_ce) begin
			ip_data <= rd_word;
		end
	end

	// Acknowledge on the cycle after the strobe
	always_ff @(posedge s_axi_aclk or negedge bus_rst_n) begin
		if (!bus_rst_n) begin
			wr_ack <= 1'b0;
			rd_ack <= 1'b0;
		end else begin
			wr_ack <= |wr_ce;
			rd_ack <= |rd_ce;
		end
	end

endmodule

// ==== hdl/axi_mux.sv ====
module axi_mux (
	input  logic                                                    s_axi_aclk,
	input  logic                                                    rst_n,
	input  logic [axi_mux_pkg::axi_addr_width-1:0]                  s_axi_awaddr,
	input  logic                                                    s_axi_awvalid,
	output logic                                                    s_axi_awready,
	input  logic [axi_mux_pkg::axi_data_width-1:0]                  s_axi_wdata,
	input  logic [axi_mux_pkg::axi_strb_width-1:0]                  s_axi_wstrb,
	input  logic                                                    s_axi_wvalid,
	output logic                                                    s_axi_wready,
	output logic [1:0]                                              s_axi_bresp,
	output logic                                                    s_axi_bvalid,
	input  logic                                                    s_axi_bready,
	input  logic [axi_mux_pkg::axi_addr_width-1:0]                  s_axi_araddr,
	input  logic                                                    s_axi_arvalid,
	output logic                                                    s_axi_arready,
	output logic [axi_mux_pkg::axi_data_width-1:0]                  s_axi_rdata,
	output logic [1:0]                                              s_axi_rresp,
	output logic                                                    s_axi_rvalid,
	input  logic                                                    s_axi_rready,
	input  logic [axi_mux_pkg::n_inputs*axi_mux_pkg::lane_width-1:0] data_in,
	output logic [axi_mux_pkg::lane_width-1:0]                      data_out
);
	import axi_mux_pkg::*;

	logic [axi_data_width-1:0] bus_data;
	logic [axi_strb_width-1:0] bus_be;
	logic [n_reg-1:0]          wr_ce;
	logic [n_reg-1:0]          rd_ce;
	logic                      bus_rst_n;
	logic [axi_data_width-1:0] ip_data;
	logic                      wr_ack;
	logic                      rd_ack;
	mux_regs_t                 params_out;
	mux_regs_t                 params_in;

	axi_lite_ipif axi_ipif (
		.s_axi_aclk    (s_axi_aclk),
		.rst_n         (rst_n),
		.s_axi_awaddr  (s_axi_awaddr),
		.s_axi_awvalid (s_axi_awvalid),
		.s_axi_awready (s_axi_awready),
		.s_axi_wdata   (s_axi_wdata),
		.s_axi_wstrb   (s_axi_wstrb),
		.s_axi_wvalid  (s_axi_wvalid),
		.s_axi_wready  (s_axi_wready),
		.s_axi_bresp   (s_axi_bresp),
		.s_axi_bvalid  (s_axi_bvalid),
		.s_axi_bready  (s_axi_bready),
		.s_axi_araddr  (s_axi_araddr),
		.s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.s_axi_rdata   (s_axi_rdata),
		.s_axi_rresp   (s_axi_rresp),
		.s_axi_rvalid  (s_axi_rvalid),
		.s_axi_rready  (s_axi_rready),
		.bus_data      (bus_data),
		.bus_be        (bus_be),
		.wr_ce         (wr_ce),
		.rd_ce         (rd_ce),
		.bus_rst_n     (bus_rst_n),
		.ip_data       (ip_data),
		.wr_ack        (wr_ack),
		.rd_ack        (rd_ack)
	);

	ipif_param_regs #(
		.param_t (mux_regs_t)
	) param_regs (
		.s_axi_aclk (s_axi_aclk),
		.bus_rst_n  (bus_rst_n),
		.bus_data   (bus_data),
		.bus_be     (bus_be),
		.wr_ce      (wr_ce),
		.rd_ce      (rd_ce),
		.params_in  (params_in),
		.ip_data    (ip_data),
		.wr_ack     (wr_ack),
		.rd_ack     (rd_ack),
		.params_out (params_out)
	);

	// Padding reads back as zero whatever was written there
	always_comb begin
		params_in          = params_out;
		params_in.pad_reg0 = '0;
		params_in.pad_reg1 = '0;
	end

	// Select codes past the last lane give a zero output
	always_comb begin
		data_out = '0;
		if (params_out.sel < sel_width'(n_inputs)) begin
			data_out = data_in[params_out.sel*lane_width +: lane_width];
		end
	end

endmodule

// ==== testbench/axi_mux_tb.sv ====
module axi_mux_tb;
	import axi_mux_pkg::*;

	localparam int timeout_cycles = 64;

	logic                           clk;
	logic                           rst_n;
	logic [axi_addr_width-1:0]      s_axi_awaddr;
	logic                           s_axi_awvalid;
	logic                           s_axi_awready;
	logic [axi_data_width-1:0]      s_axi_wdata;
	logic [axi_strb_width-1:0]      s_axi_wstrb;
	logic                           s_axi_wvalid;
	logic                           s_axi_wready;
	logic [1:0]                     s_axi_bresp;
	logic                           s_axi_bvalid;
	logic                           s_axi_bready;
	logic [axi_addr_width-1:0]      s_axi_araddr;
	logic                           s_axi_arvalid;
	logic                           s_axi_arready;
	logic [axi_data_width-1:0]      s_axi_rdata;
	logic [1:0]                     s_axi_rresp;
	logic                           s_axi_rvalid;
	logic                           s_axi_rready;
	logic [n_inputs*lane_width-1:0] data_in;
	logic [lane_width-1:0]          data_out;

	// Model of the select register and the test flow flags
	logic [sel_width-1:0] model_sel;
	logic                 lane_check_en;
	logic                 write_busy;
	logic                 data_rand_en;

	axi_mux UUT (
		.s_axi_aclk    (clk),
		.rst_n         (rst_n),
		.s_axi_awaddr  (s_axi_awaddr),
		.s_axi_awvalid (s_axi_awvalid),
		.s_axi_awready (s_axi_awready),
		.s_axi_wdata   (s_axi_wdata),
		.s_axi_wstrb   (s_axi_wstrb),
		.s_axi_wvalid  (s_axi_wvalid),
		.s_axi_wready  (s_axi_wready),
		.s_axi_bresp   (s_axi_bresp),
		.s_axi_bvalid  (s_axi_bvalid),
		.s_axi_bready  (s_axi_bready),
		.s_axi_araddr  (s_axi_araddr),
		.s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.s_axi_rdata   (s_axi_rdata),
		.s_axi_rresp   (s_axi_rresp),
		.s_axi_rvalid  (s_axi_rvalid),
		.s_axi_rready  (s_axi_rready),
		.data_in       (data_in),
		.data_out      (data_out)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Lane sel of the input word, zero for codes past the last lane
	function automatic logic [lane_width-1:0] expected_lane(
		input logic [n_inputs*lane_width-1:0] din,
		input logic [sel_width-1:0]           sel
	);
		logic [lane_width-1:0] lane;
		lane = '0;
		for (int i = 0; i < n_inputs; i++) begin
			if (int'(sel) == i) begin
				lane = din[i*lane_width +: lane_width];
			end
		end
		return lane;
	endfunction

	function automatic logic [1:0] expected_resp(input logic [axi_addr_width-1:0] addr);
		return (int'(addr) / axi_strb_width < n_reg) ? resp_okay : resp_slverr;
	endfunction

	// Only sel is visible on readback, register 1 and unmapped words read zero
	function automatic logic [axi_data_width-1:0] expected_word(
		input logic [axi_addr_width-1:0] addr
	);
		logic [axi_data_width-1:0] word;
		word = '0;
		if (int'(addr) / axi_strb_width == 0) begin
			word[sel_width-1:0] = model_sel;
		end
		return word;
	endfunction

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_lane(input string name, input logic [lane_width-1:0] exp,
			input logic [lane_width-1:0] act);
		if (act !== exp) begin
			stop_with_failure($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_word(input string name, input logic [axi_data_width-1:0] exp,
			input logic [axi_data_width-1:0] act);
		if (act !== exp) begin
			stop_with_failure($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			stop_with_failure($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic axi_write(
		input  logic [axi_addr_width-1:0] addr,
		input  logic [axi_data_width-1:0] data,
		input  logic [axi_strb_width-1:0] strb,
		input  int                        hold_cycles,
		output logic [1:0]                resp_out
	);
		int waited;
		@(negedge clk);
		s_axi_awaddr  = addr;
		s_axi_awvalid = 1'b1;
		s_axi_wdata   = data;
		s_axi_wstrb   = strb;
		s_axi_wvalid  = 1'b1;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > timeout_cycles) begin
				stop_with_failure("Write address and data were never accepted");
			end
		end while (!(s_axi_awready && s_axi_wready));
		// The transfer happens on the rising edge before this falling edge
		@(negedge clk);
		s_axi_awvalid = 1'b0;
		s_axi_wvalid  = 1'b0;
		waited = 0;
		while (!s_axi_bvalid) begin
			@(negedge clk);
			waited++;
			if (waited > timeout_cycles) begin
				stop_with_failure("No write response arrived");
			end
		end
		resp_out = s_axi_bresp;
		repeat (hold_cycles) begin
			@(negedge clk);
			if (!s_axi_bvalid) begin
				stop_with_failure("bvalid dropped while bready was low");
			end
			check_resp("bresp under back-pressure", resp_out, s_axi_bresp);
		end
		s_axi_bready = 1'b1;
		@(negedge clk);
		s_axi_bready = 1'b0;
	endtask

	task automatic axi_read(
		input  logic [axi_addr_width-1:0] addr,
		input  int                        hold_cycles,
		output logic [axi_data_width-1:0] data_out_q,
		output logic [1:0]                resp_out
	);
		int waited;
		@(negedge clk);
		s_axi_araddr  = addr;
		s_axi_arvalid = 1'b1;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > timeout_cycles) begin
				stop_with_failure("Read address was never accepted");
			end
		end while (!s_axi_arready);
		@(negedge clk);
		s_axi_arvalid = 1'b0;
		waited = 0;
		while (!s_axi_rvalid) begin
			@(negedge clk);
			waited++;
			if (waited > timeout_cycles) begin
				stop_with_failure("No read response arrived");
			end
		end
		resp_out   = s_axi_rresp;
		data_out_q = s_axi_rdata;
		repeat (hold_cycles) begin
			@(negedge clk);
			if (!s_axi_rvalid) begin
				stop_with_failure("rvalid dropped while rready was low");
			end
			check_resp("rresp under back-pressure", resp_out, s_axi_rresp);
			check_word("rdata under back-pressure", data_out_q, s_axi_rdata);
		end
		s_axi_rready = 1'b1;
		@(negedge clk);
		s_axi_rready = 1'b0;
	endtask

	// Sel lives in byte 0 of register 0, so only that strobe changes it
	task automatic write_reg(input string name, input logic [axi_addr_width-1:0] addr,
			input logic [axi_data_width-1:0] data, input logic [axi_strb_width-1:0] strb,
			input int hold_cycles);
		logic [1:0] resp;
		write_busy = 1'b1;
		axi_write(addr, data, strb, hold_cycles, resp);
		check_resp(name, expected_resp(addr), resp);
		if (expected_resp(addr) == resp_okay && int'(addr) / axi_strb_width == 0 && strb[0]) begin
			model_sel = data[sel_width-1:0];
		end
		write_busy    = 1'b0;
		lane_check_en = 1'b1;
	endtask

	task automatic read_reg(input string name, input logic [axi_addr_width-1:0] addr,
			input int hold_cycles);
		logic [1:0]                resp;
		logic [axi_data_width-1:0] word;
		axi_read(addr, hold_cycles, word, resp);
		check_resp({name, " resp"}, expected_resp(addr), resp);
		check_word({name, " data"}, expected_word(addr), word);
	endtask

	always @(negedge clk) begin
		if (data_rand_en) begin
			data_in = $urandom();
		end
	end

	// The output must follow the model on every cycle outside a write
	always begin
		@(posedge clk);
		#1;
		if (lane_check_en && !write_busy) begin
			check_lane("lane follows sel", expected_lane(data_in, model_sel), data_out);
		end
	end

	initial begin
		void'($urandom(32'h42e0));
		rst_n         = 1'b0;
		s_axi_awaddr  = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata   = '0;
		s_axi_wstrb   = '0;
		s_axi_wvalid  = 1'b0;
		s_axi_bready  = 1'b0;
		s_axi_araddr  = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready  = 1'b0;
		data_in       = '0;
		model_sel     = '0;
		lane_check_en = 1'b0;
		write_busy    = 1'b0;
		data_rand_en  = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		@(negedge clk);
		data_in = $urandom();
		read_reg("reset reg0", 11'h000, 0);
		check_lane("reset lane 0", expected_lane(data_in, '0), data_out);
		data_rand_en = 1'b1;

		for (int s = 0; s < n_inputs; s++) begin
			write_reg($sformatf("write sel %0d", s), 11'h000, axi_data_width'(s), 4'hf, 0);
			repeat (8) @(posedge clk);
		end

		// Padding bits are set on purpose and must read back as zero
		for (int s = n_inputs; s < 16; s++) begin
			write_reg($sformatf("write sel %0d", s), 11'h000,
				($urandom() & 32'hffff_fff0) | 32'hffff_0000 | axi_data_width'(s), 4'hf, 0);
			repeat (3) @(negedge clk);
			check_lane($sformatf("zero lane for sel %0d", s), '0, data_out);
			read_reg($sformatf("readback sel %0d", s), 11'h000, 0);
		end
		write_reg("write reg1", 11'h004, $urandom(), 4'hf, 0);
		read_reg("readback reg1", 11'h004, 0);

		write_reg("set sel 2", 11'h000, 32'h0000_0002, 4'hf, 0);
		write_reg("byte 0 masked", 11'h000, 32'hffff_ff01, 4'b1110, 0);
		read_reg("readback after masked write", 11'h000, 0);
		write_reg("byte 0 only", 11'h000, 32'hffff_ff03, 4'b0001, 0);
		read_reg("readback after byte 0 write", 11'h000, 0);

		write_reg("unmapped write", 11'h008, 32'h0000_0001, 4'hf, 0);
		read_reg("unmapped read", 11'h008, 0);
		write_reg("top address write", 11'h7fc, 32'h0000_0000, 4'hf, 0);
		read_reg("top address read", 11'h7fc, 0);
		read_reg("sel after unmapped access", 11'h000, 0);

		for (int i = 0; i < 6; i++) begin
			write_reg($sformatf("held write %0d", i), 11'h000, $urandom(), 4'hf,
				$urandom_range(8, 1));
			read_reg($sformatf("held read %0d", i), 11'h000, $urandom_range(8, 1));
			read_reg($sformatf("held unmapped read %0d", i), 11'h00c, $urandom_range(8, 1));
		end

		repeat (8) @(posedge clk);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== axi_mux.f ====
hdl/axi_mux_pkg.sv
hdl/axi_lite_ipif.sv
hdl/ipif_param_regs.sv
hdl/axi_mux.sv
testbench/axi_mux_tb.sv

// ==== Makefile ====
# Verilator build and run for the AXI4-Lite lane selector

VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= axi_mux_tb
FILELIST   ?= axi_mux.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides the result, the simulator status alone is not trusted
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
